//--- bench/conv_patterns.txt
// Record: ctrl word, data, wdata, then expected cube 0 to 7 results, 72 bits each
// Ctrl word hex digits: ctrl valid pad wvalid check exp_valid exp_finish
// Just out of reset, all zero
3000100 0 0  0 0 0 0  0 0 0 0
// Kernel A taps 0 to 7
3001000 0 1010020202030201  0 0 0 0  0 0 0 0
// Kernel A tap 8, upper bytes ignored
3001100 0 5a5a5a5a5a5a5a10  0 0 0 0  0 0 0 0
// Rows 0 and 1
3100000 0807060504030201 0  0 0 0 0  0 0 0 0
3100000 1817161514131211 0  0 0 0 0  0 0 0 0
// Row 2 with START, full window, cubes 6 and 7 wrap
1100110 2827262524232221 0
302010262422090401 4030202826240c0602 5040302a28260f0803 6050402c2a28120a04
7060502e2c2a150c05 807060302e2c180e06 10807022302e031007 201080242230060208
// Pad row, taps 6 to 8 go to zero
3010110 0 0
000000464442392411 0000004846443c2612 0000004a48463f2813 0000004c4a48422a14
0000004e4c4a452c15 000000504e4c482e16 00000042504e333017 000000444250362218
// HOLD, valid drops
2000100 0 0
000000464442392411 0000004846443c2612 0000004a48463f2813 0000004c4a48422a14
0000004e4c4a452c15 000000504e4c482e16 00000042504e333017 000000444250362218
// Idle
3000000 0 0  0 0 0 0  0 0 0 0
// Kernel B after the counter clear
3001000 0 0707030303010101  0 0 0 0  0 0 0 0
3001000 0 a5a5a5a5a5a5a507  0 0 0 0  0 0 0 0
// START with kernel B
1000111 0 0
000000696663131211 0000006c6966141312 0000006f6c69151413 000000726f6c161514
00000075726f171615 000000787572181716 000000637875111817 000000666378121118
// END, valid falls later
0000101 0 0
000000696663131211 0000006c6966141312 0000006f6c69151413 000000726f6c161514
00000075726f171615 000000787572181716 000000637875111817 000000666378121118
// START after END, finish stays
1000101 0 0
000000696663131211 0000006c6966141312 0000006f6c69151413 000000726f6c161514
00000075726f171615 000000787572181716 000000637875111817 000000666378121118
// Trailing idle
3000000 0 0  0 0 0 0  0 0 0 0
3000000 0 0  0 0 0 0  0 0 0 0

//--- bench/conv_props.sv
`timescale 1ns/1ps
`default_nettype none

module conv_props (
	input logic             clk,
	input logic             rst,
	input conv_pkg::state_e state,       // FSM state inside conv_ctrl
	input logic             o_res_valid,
	input logic             o_finish
);
	import conv_pkg::*;

	int fail_cnt = 0; // Failed assertion count

	// Sticky finish, only reset clears it
	a_finish_sticky: assert property (
		@(posedge clk) disable iff (!rst) o_finish |=> o_finish
	) else begin
		$error("o_finish dropped without reset");
		fail_cnt++;
	end

	// COMPUTE reaches valid after the delay line
	a_valid_high: assert property (
		@(posedge clk) disable iff (!rst)
		(state == ST_COMPUTE) |-> ##VALID_DELAY o_res_valid
	) else begin
		$error("o_res_valid missing after COMPUTE");
		fail_cnt++;
	end

	a_valid_low: assert property (
		@(posedge clk) disable iff (!rst)
		(state != ST_COMPUTE) |-> ##VALID_DELAY !o_res_valid
	) else begin
		$error("o_res_valid high without COMPUTE");
		fail_cnt++;
	end

	// Quiet outputs in reset
	a_reset_quiet: assert property (
		@(posedge clk) !rst |-> (!o_res_valid && !o_finish)
	) else begin
		$error("outputs active during reset");
		fail_cnt++;
	end

endmodule

bind conv_ctrl conv_props u_props (
	.clk         (clk),
	.rst         (rst),
	.state       (state),
	.o_res_valid (o_res_valid),
	.o_finish    (o_finish)
);

`default_nettype wire

//--- bench/conv_window_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_window_tb;
	import conv_pkg::*;

	localparam int CLK_PERIOD = 100;            // ns
	localparam int NUM_REC = 16;                // Records in the pattern file
	localparam int REC_WORDS = 3 + ROW_PIX;     // Ctrl, data, wdata, one word per cube
	localparam int CHECK_LAG = VALID_DELAY + 1; // Edge that takes the record, then pipeline

	logic                 clk;
	logic                 rst;
	logic [1:0]           ctrl;
	logic [ROW_W-1:0]     data;
	logic                 valid;
	logic                 pad;
	logic [ROW_W-1:0]     wdata;
	logic                 wvalid;
	logic [OUT_W-1:0]     result;
	logic                 res_valid;
	logic                 finish;

	logic [TAP_VEC_W-1:0] pat_mem [NUM_REC*REC_WORDS]; // Whole pattern file
	int                   err_cnt;
	int                   chk_cnt;
	int                   prop_fails; // Bound checker failures

	conv_window_top u_conv_window_top (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (ctrl),
		.i_data      (data),
		.i_valid     (valid),
		.i_pad       (pad),
		.i_wdata     (wdata),
		.i_wvalid    (wvalid),
		.o_result    (result),
		.o_res_valid (res_valid),
		.o_finish    (finish)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// Ctrl word digits, ctrl valid pad wvalid check exp_valid exp_finish
	task automatic drive_record(input int r);
		logic [TAP_VEC_W-1:0] ctl_w;
		ctl_w = pat_mem[r*REC_WORDS];
		ctrl <= ctl_w[25:24];
		valid <= ctl_w[20];
		pad <= ctl_w[16];
		wvalid <= ctl_w[12];
		if (ctl_w[20]) begin
			data <= pat_mem[r*REC_WORDS+1][ROW_W-1:0];
		end else begin
			data <= {$urandom, $urandom}; // Don't care, must not reach the rows
		end
		if (ctl_w[12]) begin
			wdata <= pat_mem[r*REC_WORDS+2][ROW_W-1:0];
		end else begin
			wdata <= {$urandom, $urandom}; // Ignored without wvalid
		end
	endtask

	task automatic drive_idle();
		ctrl <= CTRL_IDLE;
		valid <= 1'b0;
		pad <= 1'b0;
		wvalid <= 1'b0;
		data <= {$urandom, $urandom};
		wdata <= {$urandom, $urandom};
	endtask

	task automatic check_record(input int r);
		logic [TAP_VEC_W-1:0] ctl_w;
		logic [TAP_VEC_W-1:0] exp_cube;
		logic [TAP_VEC_W-1:0] got_cube;
		ctl_w = pat_mem[r*REC_WORDS];
		if (ctl_w[8]) begin
			chk_cnt++;
			if (res_valid !== ctl_w[4]) begin
				err_cnt++;
				$display("ERR %0t ns rec %0d o_res_valid exp %b got %b",
					$time, r, ctl_w[4], res_valid);
			end
			if (finish !== ctl_w[0]) begin
				err_cnt++;
				$display("ERR %0t ns rec %0d o_finish exp %b got %b",
					$time, r, ctl_w[0], finish);
			end
			for (int p = 0; p < ROW_PIX; p++) begin
				exp_cube = pat_mem[r*REC_WORDS+3+p];
				got_cube = result[p*TAP_VEC_W +: TAP_VEC_W];
				if (got_cube !== exp_cube) begin
					err_cnt++;
					$display("ERR %0t ns rec %0d o_result cube %0d exp %h got %h",
						$time, r, p, exp_cube, got_cube);
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		ctrl = CTRL_IDLE;
		data = '0;
		valid = 1'b0;
		pad = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		err_cnt = 0;
		chk_cnt = 0;
		prop_fails = 0;
		void'($urandom(32'hf9e6)); // Seed for idle data
		$readmemh("bench/conv_patterns.txt", pat_mem);
		if ($isunknown(pat_mem[NUM_REC*REC_WORDS-1])) begin
			err_cnt++;
			$display("Pattern file bench/conv_patterns.txt is missing or too short");
		end
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		// Record i is driven here, taken at the next edge, checked CHECK_LAG loops later
		for (int i = 0; i < NUM_REC + CHECK_LAG; i++) begin
			@(posedge clk);
			if (i < NUM_REC) begin
				drive_record(i);
			end else begin
				drive_idle();
			end
			@(negedge clk); // Outputs settled mid cycle
			if (i >= CHECK_LAG) begin
				check_record(i - CHECK_LAG);
			end
		end
		prop_fails = u_conv_window_top.u_ctrl.u_props.fail_cnt;
		$display("Done, %0d records checked, %0d errors, %0d assertion failures",
			chk_cnt, err_cnt, prop_fails);
		if (err_cnt == 0 && prop_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog, run length plus margin
	initial begin
		#((NUM_REC + 20) * CLK_PERIOD);
		$display("Timeout, run did not end within %0d cycles", NUM_REC + 20);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- conv_window.f
source/conv_pkg.sv
source/cube_if.sv
source/conv_ctrl.sv
source/row_shifter.sv
source/weight_loader.sv
source/pixel_cube.sv
source/conv_window_top.sv
bench/conv_props.sv
bench/conv_window_tb.sv

//--- source/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
	input  logic            clk,
	input  logic            rst,
	input  conv_pkg::ctrl_e i_ctrl,      // Level, sampled every edge
	output logic            o_hold,      // Decoded HOLD for the weight counter
	output logic            o_res_valid, // COMPUTE delayed to match the cubes
	output logic            o_finish     // Sticky once FINISH is reached
);
	import conv_pkg::*;

	state_e state;
	state_e state_nxt;
	logic [VALID_DELAY-1:0] vld_sr; // Bit 0 is the newest stage

	assign o_hold = (i_ctrl == CTRL_HOLD); // Only place the code is decoded
	assign o_finish = (state == ST_FINISH);
	assign o_res_valid = vld_sr[VALID_DELAY-1];

	always_comb begin
		state_nxt = state; // Stay by default, IDLE lands here
		case (state)
			ST_WAIT: begin
				if (i_ctrl == CTRL_START) begin
					state_nxt = ST_COMPUTE;
				end else if (i_ctrl == CTRL_END) begin
					state_nxt = ST_FINISH;
				end
			end
			ST_COMPUTE: begin
				if (i_ctrl == CTRL_HOLD) begin
					state_nxt = ST_WAIT; // Pause, weights may be reloaded
				end else if (i_ctrl == CTRL_END) begin
					state_nxt = ST_FINISH;
				end
			end
			ST_FINISH: begin
				state_nxt = ST_FINISH; // Absorbing
			end
			default: begin
				state_nxt = ST_WAIT; // Unused code recovers to WAIT
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_WAIT;
		end else begin
			state <= state_nxt;
		end
	end

	// Three stages line up with snapshot, window and product registers
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[VALID_DELAY-2:0], (state == ST_COMPUTE)};
		end
	end

endmodule

`default_nettype wire

//--- source/conv_pkg.sv
`default_nettype none

package conv_pkg;

	localparam int PIX_W = 8;                     // One pixel or one weight
	localparam int ROW_PIX = 8;                   // Pixels per row word
	localparam int ROW_W = PIX_W * ROW_PIX;       // 64-bit row word
	localparam int KSIZE = 3;                     // Kernel side
	localparam int KTAPS = KSIZE * KSIZE;         // Nine taps
	localparam int TAP_VEC_W = KTAPS * PIX_W;     // Kernel or one cube result

	localparam int WT_WORDS = 2;                  // Weight words per kernel
	localparam int WCNT_W = $clog2(WT_WORDS + 1); // Counter reaches WT_WORDS
	localparam int VALID_DELAY = 3;               // COMPUTE to result valid
	localparam int OUT_W = ROW_PIX * TAP_VEC_W;   // All eight cube results

	// Control codes on the ctrl level input
	typedef enum logic [1:0] {
		CTRL_END   = 2'd0, // Go to FINISH
		CTRL_START = 2'd1, // WAIT to COMPUTE
		CTRL_HOLD  = 2'd2, // COMPUTE to WAIT, weight counter clear
		CTRL_IDLE  = 2'd3  // No effect
	} ctrl_e;

	// Engine states, WAIT is the reset state
	typedef enum logic [1:0] {
		ST_WAIT    = 2'd0,
		ST_COMPUTE = 2'd1,
		ST_FINISH  = 2'd2
	} state_e;

endpackage

`default_nettype wire

//--- source/conv_window_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_window_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [1:0]                 i_ctrl,      // END, START, HOLD, IDLE
	input  logic [conv_pkg::ROW_W-1:0] i_data,      // Image row
	input  logic                       i_valid,     // Row strobe
	input  logic                       i_pad,       // Zero row strobe
	input  logic [conv_pkg::ROW_W-1:0] i_wdata,     // Weight word
	input  logic                       i_wvalid,    // Weight strobe
	output logic [conv_pkg::OUT_W-1:0] o_result,    // Cube p in bytes 9p..9p+8
	output logic                       o_res_valid,
	output logic                       o_finish
);
	import conv_pkg::*;

	logic hold; // HOLD decode, control to weight loader

	cube_if u_bus ();

	conv_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (ctrl_e'(i_ctrl)),
		.o_hold      (hold),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish)
	);

	row_shifter u_rows (
		.clk     (clk),
		.rst     (rst),
		.i_data  (i_data),
		.i_valid (i_valid),
		.i_pad   (i_pad),
		.o_rows  (u_bus.row_src)
	);

	weight_loader u_wts (
		.clk      (clk),
		.rst      (rst),
		.i_wdata  (i_wdata),
		.i_wvalid (i_wvalid),
		.i_hold   (hold),
		.o_wts    (u_bus.wt_src)
	);

	// One cube per column position, all share rows and kernel
	for (genvar p = 0; p < ROW_PIX; p++) begin : g_cube
		pixel_cube #(
			.POS (p)
		) u_cube (
			.clk      (clk),
			.rst      (rst),
			.i_cube   (u_bus.sink),
			.o_result (o_result[p*TAP_VEC_W +: TAP_VEC_W])
		);
	end

endmodule

`default_nettype wire

//--- source/cube_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cube_if;
	import conv_pkg::*;

	logic [ROW_W-1:0]     row_old; // Window row 0
	logic [ROW_W-1:0]     row_mid; // Window row 1
	logic [ROW_W-1:0]     row_new; // Window row 2, latest row
	logic [TAP_VEC_W-1:0] kernel;  // Nine weights, tap t in byte t

	modport row_src (
		output row_old,
		output row_mid,
		output row_new
	);

	modport wt_src (
		output kernel
	);

	modport sink (
		input row_old,
		input row_mid,
		input row_new,
		input kernel
	);

endinterface

`default_nettype wire

//--- source/pixel_cube.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_cube #(
	parameter int POS = 0 // Window column, wraps past pixel 7
) (
	input  logic                           clk,
	input  logic                           rst,
	cube_if.sink                           i_cube,
	output logic [conv_pkg::TAP_VEC_W-1:0] o_result // Byte t is tap t product
);
	import conv_pkg::*;

	logic [ROW_W-1:0]     rows [KSIZE];   // Row 0 oldest
	logic [TAP_VEC_W-1:0] win;            // Selected 3x3 window
	logic [TAP_VEC_W-1:0] win_q;
	logic [TAP_VEC_W-1:0] kern_q;
	logic [PIX_W-1:0]     prod [KTAPS];   // Low byte of each product

	assign rows[0] = i_cube.row_old;
	assign rows[1] = i_cube.row_mid;
	assign rows[2] = i_cube.row_new;

	// Tap 3r+k takes pixel (POS+k) mod 8 of row r
	for (genvar r = 0; r < KSIZE; r++) begin : g_row
		for (genvar k = 0; k < KSIZE; k++) begin : g_col
			localparam int COL = (POS + k) % ROW_PIX; // Wrap inside the row
			assign win[(KSIZE*r+k)*PIX_W +: PIX_W] = rows[r][COL*PIX_W +: PIX_W];
		end
	end

	// Window and kernel register stage
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_q <= '0;
			kern_q <= '0;
		end else begin
			win_q <= win;
			kern_q <= i_cube.kernel;
		end
	end

	always_comb begin
		for (int t = 0; t < KTAPS; t++) begin
			prod[t] = kern_q[t*PIX_W +: PIX_W] * win_q[t*PIX_W +: PIX_W]; // 8-bit context
		end
	end

	// Product stage, low byte of each product only
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_result <= '0;
		end else begin
			for (int t = 0; t < KTAPS; t++) begin
				o_result[t*PIX_W +: PIX_W] <= prod[t];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/row_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module row_shifter (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [conv_pkg::ROW_W-1:0] i_data,  // New row of eight pixels
	input  logic                       i_valid, // i_data strobe
	input  logic                       i_pad,   // Left padding, shifts in zeros
	cube_if.row_src                    o_rows
);
	import conv_pkg::*;

	logic [ROW_W-1:0] row_a; // Oldest row
	logic [ROW_W-1:0] row_b;
	logic [ROW_W-1:0] row_c; // Latest row
	logic [ROW_W-1:0] row_in;
	logic             shift;

	assign shift = i_valid | i_pad;
	assign row_in = i_valid ? i_data : '0; // Pad alone gives a zero row

	// Row history, moves toward row_a
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_a <= '0;
			row_b <= '0;
			row_c <= '0;
		end else if (shift) begin
			row_a <= row_b;
			row_b <= row_c;
			row_c <= row_in;
		end
	end

	// Snapshot stage, one cycle behind the history, feeds every cube
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_rows.row_old <= '0;
			o_rows.row_mid <= '0;
			o_rows.row_new <= '0;
		end else begin
			o_rows.row_old <= row_a;
			o_rows.row_mid <= row_b;
			o_rows.row_new <= row_c;
		end
	end

endmodule

`default_nettype wire

//--- source/weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [conv_pkg::ROW_W-1:0] i_wdata,  // Eight weights per word
	input  logic                       i_wvalid, // i_wdata strobe
	input  logic                       i_hold,   // HOLD seen, restart the count
	cube_if.wt_src                     o_wts
);
	import conv_pkg::*;

	localparam int TAIL_W = TAP_VEC_W - ROW_W; // Ninth weight from word 1

	logic [WCNT_W-1:0] wcnt;    // Words taken since the last HOLD
	logic              wr_en;

	assign wr_en = i_wvalid && (wcnt < WCNT_W'(WT_WORDS)); // Extra words ignored

	// Word counter, saturates at WT_WORDS
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wcnt <= '0;
		end else if (i_hold) begin
			wcnt <= '0;
		end else if (wr_en) begin
			wcnt <= wcnt + 1'b1;
		end
	end

	// Kernel bytes by word index, old kernel stays until overwritten
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_wts.kernel <= '0;
		end else if (wr_en) begin
			case (wcnt)
				WCNT_W'(0): begin
					o_wts.kernel[ROW_W-1:0] <= i_wdata; // Taps 0 to 7
				end
				WCNT_W'(1): begin
					o_wts.kernel[TAP_VEC_W-1:ROW_W] <= i_wdata[TAIL_W-1:0]; // Tap 8
				end
				default: begin
					o_wts.kernel <= o_wts.kernel;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
